// ==== flist.f ====
hdl/corePkg.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/fetchDecode.sv
hdl/executeUnit.sv
hdl/memResult.sv
hdl/pipeCore.sv
test/pipeCoreChk.sv
test/tbPipeCore.sv

// ==== Makefile ====
SRCS := $(shell cat flist.f)

obj_dir/tbPipeCore: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tbPipeCore -f flist.f -o tbPipeCore

run: obj_dir/tbPipeCore
	-obj_dir/tbPipeCore +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== test/tbPipeCore.sv ====
`timescale 1ns/100ps

module tbPipeCore;

	localparam corePkg::word resetPc = 32'h0000_0080;
	localparam int progLen = 70;
	localparam int worstCpi = 8;
	localparam int cycleLimit = progLen * worstCpi * 3 + 320; // Reset and end loop margin

	logic clk = 1'b0;
	logic rstN;
	corePkg::instr imemData;
	corePkg::word imemAddr;
	corePkg::word wbDatR;
	logic wbAck;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	corePkg::word wbAdr;
	corePkg::word wbDatW;
	logic [3:0] wbSel;
	logic retireValid;
	corePkg::word retirePc;
	corePkg::regIdx retireRd;
	corePkg::word retireData;

	corePkg::instr rom [128];
	corePkg::word mem [256];
	corePkg::word markerPc [8];
	logic [6:0] loadPtr;
	logic [2:0] testIdx;
	logic [31:0] rngState = 32'hd821;
	logic slaveBusy = 1'b0;
	int waitLeft = 0;
	int cycles = 0;
	int errMark = 0;
	int testsFailed = 0;

	pipeCore #(
		.resetPc(resetPc)
	) dut (
		.clk(clk),
		.rstN(rstN),
		.imemData(imemData),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.imemAddr(imemAddr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbSel(wbSel),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireRd(retireRd),
		.retireData(retireData)
	);

	bind pipeCore pipeCoreChk #(.resetPc(resetPc)) chk (
		.clk(clk),
		.rstN(rstN),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireRd(retireRd),
		.retireData(retireData),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbSel(wbSel),
		.wbAck(wbAck)
	);

	always #5 clk = ~clk;

	assign imemData = rom[imemAddr[8:2]]; // Combinational fetch

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic corePkg::instr encodeReg(input int rs, input int rt, input int rd,
			input logic [5:0] fn);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic corePkg::instr encodeImm(input logic [5:0] op, input int rs,
			input int rt, input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic string sectionName(input logic [2:0] idx);
		case (idx)
			3'd0: return "alu forwarding";
			3'd1: return "load use";
			3'd2: return "store then load";
			3'd3: return "branches";
			default: return "mixed memory";
		endcase
	endfunction

	task automatic putInstr(input corePkg::instr ins);
		rom[loadPtr] = ins;
		loadPtr = loadPtr + 7'd1;
	endtask

	task automatic markTest(input logic [2:0] idx);
		markerPc[idx] = 32'({loadPtr, 2'b00});
		putInstr(32'h0); // NOP at the marker PC
	endtask

	task automatic loadProgram;
		for (int i = 0; i < 128; i++)
			rom[7'(i)] = 32'h0;
		loadPtr = resetPc[8:2];
		putInstr(encodeImm(corePkg::opAddiu, 0, 1, 5));
		putInstr(encodeImm(corePkg::opAddiu, 0, 2, -3));
		putInstr(encodeReg(1, 2, 3, corePkg::fnAddu));
		putInstr(encodeReg(3, 1, 4, corePkg::fnSubu));
		putInstr(encodeReg(4, 3, 5, corePkg::fnAnd));
		putInstr(encodeReg(5, 2, 6, corePkg::fnOr));
		putInstr(encodeReg(2, 1, 7, corePkg::fnSlt));
		putInstr(encodeReg(1, 2, 8, corePkg::fnSlt));
		putInstr(encodeImm(corePkg::opAddiu, 0, 0, 77)); // r0 must stay zero
		putInstr(encodeReg(0, 1, 9, corePkg::fnAddu));
		putInstr(encodeReg(9, 7, 10, corePkg::fnSubu));
		markTest(3'd0);
		putInstr(encodeImm(corePkg::opAddiu, 0, 11, 32'h40));
		putInstr(encodeImm(corePkg::opLw, 11, 12, 0));
		putInstr(encodeReg(12, 1, 13, corePkg::fnAddu));
		putInstr(encodeImm(corePkg::opLw, 11, 14, 4));
		putInstr(encodeImm(corePkg::opAddiu, 14, 15, 1));
		putInstr(encodeImm(corePkg::opLw, 11, 16, 8));
		putInstr(encodeReg(0, 0, 17, corePkg::fnOr));
		putInstr(encodeReg(16, 12, 18, corePkg::fnSubu));
		markTest(3'd1);
		putInstr(encodeImm(corePkg::opAddiu, 0, 20, 32'h100));
		putInstr(encodeImm(corePkg::opSw, 20, 3, 0));
		putInstr(encodeImm(corePkg::opSw, 20, 7, 4));
		putInstr(encodeImm(corePkg::opLw, 20, 21, 0));
		putInstr(encodeImm(corePkg::opLw, 20, 22, 4));
		putInstr(encodeReg(21, 22, 23, corePkg::fnAddu));
		putInstr(encodeImm(corePkg::opSw, 20, 23, 8));
		putInstr(encodeImm(corePkg::opLw, 20, 24, 8));
		putInstr(encodeImm(corePkg::opSw, 20, 24, -4));
		putInstr(encodeImm(corePkg::opLw, 20, 25, -4));
		markTest(3'd2);
		putInstr(encodeImm(corePkg::opAddiu, 0, 26, 7));
		putInstr(encodeImm(corePkg::opAddiu, 0, 27, 7));
		putInstr(encodeImm(corePkg::opBeq, 26, 27, 1)); // Taken
		putInstr(encodeImm(corePkg::opAddiu, 0, 28, 99));
		putInstr(encodeImm(corePkg::opAddiu, 0, 28, 1));
		putInstr(encodeImm(corePkg::opBne, 26, 27, 1)); // Not taken
		putInstr(encodeImm(corePkg::opAddiu, 0, 29, 2));
		putInstr(encodeImm(corePkg::opAddiu, 26, 26, 1));
		putInstr(encodeImm(corePkg::opBne, 26, 27, 2)); // Operand straight from EX
		putInstr(encodeImm(corePkg::opAddiu, 0, 29, 55));
		putInstr(encodeImm(corePkg::opAddiu, 0, 29, 66));
		putInstr(encodeImm(corePkg::opBeq, 26, 27, 1));
		putInstr(encodeImm(corePkg::opAddiu, 0, 30, 3));
		putInstr(encodeImm(corePkg::opLw, 11, 31, 0));
		putInstr(encodeImm(corePkg::opBeq, 31, 12, 1)); // Waits on the load
		putInstr(encodeImm(corePkg::opAddiu, 0, 30, 77));
		putInstr(encodeImm(corePkg::opAddiu, 0, 19, 3));
		putInstr(encodeImm(corePkg::opAddiu, 19, 19, -1));
		putInstr(encodeImm(corePkg::opBne, 19, 0, -2)); // Backward loop
		markTest(3'd3);
		putInstr(encodeImm(corePkg::opAddiu, 0, 2, 32'h200));
		putInstr(encodeImm(corePkg::opSw, 2, 26, 0));
		putInstr(encodeImm(corePkg::opLw, 2, 3, 0));
		putInstr(encodeReg(3, 3, 4, corePkg::fnAddu));
		putInstr(encodeImm(corePkg::opSw, 2, 4, 4));
		putInstr(encodeImm(corePkg::opLw, 2, 5, 4));
		putInstr(encodeImm(corePkg::opBeq, 5, 4, 1));
		putInstr(encodeImm(corePkg::opSw, 2, 0, 0));
		putInstr(encodeImm(corePkg::opLw, 2, 6, 0));
		putInstr(encodeReg(6, 5, 7, corePkg::fnSlt));
		markTest(3'd4);
		putInstr(encodeImm(corePkg::opBeq, 0, 0, -1)); // Park here
	endtask

	// Wishbone slave with 0 to 3 wait states
	always @(posedge clk) begin
		#1;
		if (wbAck) begin
			wbAck = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!slaveBusy) begin
				slaveBusy = 1'b1;
				rngState = nextRandom(rngState);
				waitLeft = int'(rngState[17:16]);
			end
			if (waitLeft == 0) begin
				if (wbWe)
					mem[wbAdr[9:2]] = wbDatW;
				wbDatR = mem[wbAdr[9:2]];
				wbAck = 1'b1;
				slaveBusy = 1'b0;
			end else begin
				waitLeft--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == cycleLimit) begin
			$display("Timeout after %0d cycles, test %0d never reached its marker",
				cycles, testIdx);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		wbAck = 1'b0;
		wbDatR = 32'h0;
		testIdx = 3'd0;
		loadProgram();
		for (int i = 0; i < 256; i++)
			mem[8'(i)] = (32'(i) << 2) * 32'h9e37_79b1 + 32'h0000_1234;
		repeat (8) @(posedge clk);
		#1 rstN = 1'b1;
		while (testIdx != 3'd5) begin
			@(posedge clk);
			#1;
			if (retireValid && retirePc == markerPc[testIdx]) begin
				@(posedge clk); // Checker judges the marker retire on this edge
				#1;
				if (dut.chk.errCount != errMark)
					testsFailed++;
				$display("Test %0d %s: %s, %0d assertion failures", testIdx + 3'd1,
					sectionName(testIdx), (dut.chk.errCount != errMark) ? "FAIL" : "ok",
					dut.chk.errCount - errMark);
				errMark = dut.chk.errCount;
				testIdx = testIdx + 3'd1;
			end
		end
		$display("Summary: 5 tests, %0d passed, %0d failed, %0d assertion failures",
			5 - testsFailed, testsFailed, dut.chk.errCount);
		if (testsFailed == 0 && dut.chk.errCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== test/pipeCoreChk.sv ====
`timescale 1ns/100ps

module pipeCoreChk #(
	parameter corePkg::word resetPc = 32'h0
) (
	input logic clk,
	input logic rstN,
	input logic retireValid,
	input corePkg::word retirePc,
	input corePkg::regIdx retireRd,
	input corePkg::word retireData,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input corePkg::word wbAdr,
	input corePkg::word wbDatW,
	input logic [3:0] wbSel,
	input logic wbAck
);

	int errCount = 0;
	corePkg::word shadowReg [32];
	corePkg::word shadowMem [256];
	corePkg::word pcExp; // PC the next retire must carry
	corePkg::instr curInstr;
	corePkg::word va;
	corePkg::word vb;
	corePkg::word imm;
	corePkg::word memAddr;
	corePkg::word stepPc;
	corePkg::regIdx expRd;
	corePkg::word expData;
	logic isStore;

	// Architectural effect of the retiring instruction
	always_comb begin
		curInstr = tbPipeCore.rom[retirePc[8:2]];
		va = shadowReg[curInstr[25:21]];
		vb = shadowReg[curInstr[20:16]];
		imm = {{16{curInstr[15]}}, curInstr[15:0]};
		memAddr = va + imm;
		stepPc = retirePc + 32'd4;
		expRd = 5'd0;
		expData = 32'd0;
		isStore = 1'b0;
		case (curInstr[31:26])
			corePkg::opSpecial: begin
				expRd = curInstr[15:11];
				case (curInstr[5:0])
					corePkg::fnAddu: expData = va + vb;
					corePkg::fnSubu: expData = va - vb;
					corePkg::fnAnd: expData = va & vb;
					corePkg::fnOr: expData = va | vb;
					corePkg::fnSlt: expData = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
					default: expRd = 5'd0; // NOP
				endcase
			end
			corePkg::opAddiu: begin
				expRd = curInstr[20:16];
				expData = memAddr;
			end
			corePkg::opLw: begin
				expRd = curInstr[20:16];
				expData = shadowMem[memAddr[9:2]];
			end
			corePkg::opSw: isStore = 1'b1;
			corePkg::opBeq: if (va == vb) stepPc = retirePc + 32'd4 + (imm << 2);
			corePkg::opBne: if (va != vb) stepPc = retirePc + 32'd4 + (imm << 2);
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcExp <= resetPc;
			for (int i = 0; i < 32; i++)
				shadowReg[5'(i)] <= 32'd0;
			for (int i = 0; i < 256; i++)
				shadowMem[8'(i)] <= tbPipeCore.mem[8'(i)]; // Slave memory before any store
		end else if (retireValid) begin
			if (expRd != 5'd0)
				shadowReg[expRd] <= expData;
			if (isStore)
				shadowMem[memAddr[9:2]] <= vb;
			pcExp <= stepPc;
		end
	end

	retireOrder: assert property (@(posedge clk) disable iff (!rstN)
		retireValid |-> retirePc == pcExp)
		else begin
			errCount++;
			$error("Mismatch at %0t: retirePc is %h, expected %h", $time,
				$sampled(retirePc), $sampled(pcExp));
		end

	retireDest: assert property (@(posedge clk) disable iff (!rstN)
		retireValid |-> retireRd == expRd)
		else begin
			errCount++;
			$error("Mismatch at %0t: retireRd is %0d, expected %0d", $time,
				$sampled(retireRd), $sampled(expRd));
		end

	retireValue: assert property (@(posedge clk) disable iff (!rstN)
		retireValid && expRd != 5'd0 |-> retireData == expData)
		else begin
			errCount++;
			$error("Mismatch at %0t: retireData is %h, expected %h", $time,
				$sampled(retireData), $sampled(expData));
		end

	busHold: assert property (@(posedge clk) disable iff (!rstN)
		wbCyc && !wbAck |=> wbCyc && wbStb && $stable(wbAdr) && $stable(wbDatW)
			&& $stable(wbWe))
		else begin
			errCount++;
			$error("Bus request dropped or changed before ack at %0t", $time);
		end

	busSel: assert property (@(posedge clk) disable iff (!rstN)
		wbCyc |-> wbSel == 4'hf)
		else begin
			errCount++;
			$error("Mismatch at %0t: wbSel is %h, expected f", $time, $sampled(wbSel));
		end

	busRelease: assert property (@(posedge clk) disable iff (!rstN)
		wbCyc && wbAck |=> !wbCyc)
		else begin
			errCount++;
			$error("Bus cycle still open after ack at %0t", $time);
		end

	resetQuiet: assert property (@(posedge clk) !rstN |=> !wbCyc && !retireValid)
		else begin
			errCount++;
			$error("Bus cycle or retire active during reset at %0t", $time);
		end

endmodule

// ==== hdl/pipeCore.sv ====
`timescale 1ns/100ps

module pipeCore #(
	parameter corePkg::word resetPc = 32'h0
) (
	input logic clk,
	input logic rstN,
	input corePkg::instr imemData,
	input corePkg::word wbDatR,
	input logic wbAck,
	output corePkg::word imemAddr,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output corePkg::word wbAdr,
	output corePkg::word wbDatW,
	output logic [3:0] wbSel,
	output logic retireValid,
	output corePkg::word retirePc,
	output corePkg::regIdx retireRd,
	output corePkg::word retireData
);

	corePkg::regIdx idRs;
	corePkg::regIdx idRt;
	corePkg::regIdx idRd;
	corePkg::regIdx exRd;
	corePkg::regIdx memRd;
	corePkg::regIdx wbRd;
	corePkg::word idPc;
	corePkg::word idOpA;
	corePkg::word idOpB;
	corePkg::word idImm;
	corePkg::word exPc;
	corePkg::word exResult;
	corePkg::word exStoreData;
	corePkg::word memFwdData;
	corePkg::word wbData;
	corePkg::aluOp idAluOp;
	corePkg::fwdSel fwdA;
	corePkg::fwdSel fwdB;
	logic idBranch;
	logic idValid;
	logic idRegWr;
	logic idMemRd;
	logic idMemWr;
	logic exValid;
	logic exRegWr;
	logic exMemRd;
	logic exMemWr;
	logic memRegWr;
	logic memMemRd;
	logic memBusy;
	logic wbRegWr;
	logic pcWr;
	logic ifIdWr;
	logic idExBubble;
	logic pipeHold;

	fetchDecode #(
		.resetPc(resetPc)
	) fetchDecode0 (
		.clk(clk),
		.rstN(rstN),
		.imemData(imemData),
		.pcWr(pcWr),
		.ifIdWr(ifIdWr),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.exResult(exResult),
		.memFwdData(memFwdData),
		.wbData(wbData),
		.wbWe(wbRegWr), // Register file write enable
		.wbRd(wbRd),
		.imemAddr(imemAddr),
		.idRs(idRs),
		.idRt(idRt),
		.idBranch(idBranch),
		.idValid(idValid),
		.idPc(idPc),
		.idOpA(idOpA),
		.idOpB(idOpB),
		.idImm(idImm),
		.idRd(idRd),
		.idAluOp(idAluOp),
		.idRegWr(idRegWr),
		.idMemRd(idMemRd),
		.idMemWr(idMemWr)
	);

	hazardUnit hazardUnit0 (
		.idRs(idRs),
		.idRt(idRt),
		.idBranch(idBranch),
		.exRd(exRd),
		.exRegWr(exRegWr),
		.exMemRd(exMemRd),
		.memRd(memRd),
		.memRegWr(memRegWr),
		.memMemRd(memMemRd),
		.wbRd(wbRd),
		.wbRegWr(wbRegWr),
		.memBusy(memBusy),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.pcWr(pcWr),
		.ifIdWr(ifIdWr),
		.idExBubble(idExBubble),
		.pipeHold(pipeHold)
	);

	executeUnit executeUnit0 (
		.clk(clk),
		.rstN(rstN),
		.pipeHold(pipeHold),
		.idExBubble(idExBubble),
		.idValid(idValid),
		.idPc(idPc),
		.idOpA(idOpA),
		.idOpB(idOpB),
		.idImm(idImm),
		.idRd(idRd),
		.idAluOp(idAluOp),
		.idRegWr(idRegWr),
		.idMemRd(idMemRd),
		.idMemWr(idMemWr),
		.exValid(exValid),
		.exPc(exPc),
		.exRd(exRd),
		.exRegWr(exRegWr),
		.exMemRd(exMemRd),
		.exMemWr(exMemWr),
		.exResult(exResult),
		.exStoreData(exStoreData)
	);

	memResult memResult0 (
		.clk(clk),
		.rstN(rstN),
		.pipeHold(pipeHold),
		.exValid(exValid),
		.exPc(exPc),
		.exRd(exRd),
		.exRegWr(exRegWr),
		.exMemRd(exMemRd),
		.exMemWr(exMemWr),
		.exResult(exResult),
		.exStoreData(exStoreData),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbSel(wbSel),
		.memBusy(memBusy),
		.memRd(memRd),
		.memRegWr(memRegWr),
		.memMemRd(memMemRd),
		.memFwdData(memFwdData),
		.wbRd(wbRd),
		.wbRegWr(wbRegWr),
		.wbData(wbData),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireRd(retireRd),
		.retireData(retireData)
	);

endmodule

// ==== hdl/memResult.sv ====
`timescale 1ns/100ps

module memResult (
	input logic clk,
	input logic rstN,
	input logic pipeHold,
	input logic exValid,
	input corePkg::word exPc,
	input corePkg::regIdx exRd,
	input logic exRegWr,
	input logic exMemRd,
	input logic exMemWr,
	input corePkg::word exResult,
	input corePkg::word exStoreData,
	input corePkg::word wbDatR,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output corePkg::word wbAdr,
	output corePkg::word wbDatW,
	output logic [3:0] wbSel,
	output logic memBusy,
	output corePkg::regIdx memRd,
	output logic memRegWr,
	output logic memMemRd,
	output corePkg::word memFwdData,
	output corePkg::regIdx wbRd,
	output logic wbRegWr,
	output corePkg::word wbData,
	output logic retireValid,
	output corePkg::word retirePc,
	output corePkg::regIdx retireRd,
	output corePkg::word retireData
);

	typedef enum logic {
		idle,
		access
	} busState;

	busState state;
	busState stateNext;
	logic memValid;
	logic memMemWr;
	logic memReq;
	corePkg::word memPc;
	corePkg::word memAluOut;
	corePkg::word memStoreData;
	corePkg::word wbPc;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memValid <= 1'b0;
			memRegWr <= 1'b0;
			memMemRd <= 1'b0;
			memMemWr <= 1'b0;
		end else if (!pipeHold) begin
			memValid <= exValid;
			memRegWr <= exRegWr;
			memMemRd <= exMemRd;
			memMemWr <= exMemWr;
			memPc <= exPc;
			memRd <= exRd;
			memAluOut <= exResult;
			memStoreData <= exStoreData;
		end
	end

	assign memReq = memValid & (memMemRd | memMemWr);

	// Idle one cycle between accesses so cyc drops after every ack
	always_comb begin
		stateNext = state;
		memBusy = 1'b0;
		case (state)
			idle: begin
				memBusy = memReq;
				if (memReq)
					stateNext = access;
			end
			access: begin
				memBusy = !wbAck;
				if (wbAck)
					stateNext = idle;
			end
			default: stateNext = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= idle;
		else
			state <= stateNext;
	end

	assign wbCyc = (state == access);
	assign wbStb = (state == access);
	assign wbWe = memMemWr;
	assign wbAdr = memAluOut; // Held with the frozen EX/MEM register
	assign wbDatW = memStoreData;
	assign wbSel = 4'hf;

	// Read data is valid in the ack cycle, when the pipe moves
	assign memFwdData = memMemRd ? wbDatR : memAluOut;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbRegWr <= 1'b0;
			retireValid <= 1'b0;
		end else begin
			retireValid <= !pipeHold && memValid; // One pulse per instruction
			if (!pipeHold)
				wbRegWr <= memRegWr;
		end
	end

	always_ff @(posedge clk) begin
		if (!pipeHold) begin
			wbPc <= memPc;
			wbRd <= memRd;
			wbData <= memFwdData;
		end
	end

	assign retirePc = wbPc;
	assign retireRd = wbRegWr ? wbRd : 5'd0;
	assign retireData = wbData;

endmodule

// ==== hdl/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
	input logic clk,
	input logic rstN,
	input logic pipeHold,
	input logic idExBubble,
	input logic idValid,
	input corePkg::word idPc,
	input corePkg::word idOpA,
	input corePkg::word idOpB,
	input corePkg::word idImm,
	input corePkg::regIdx idRd,
	input corePkg::aluOp idAluOp,
	input logic idRegWr,
	input logic idMemRd,
	input logic idMemWr,
	output logic exValid,
	output corePkg::word exPc,
	output corePkg::regIdx exRd,
	output logic exRegWr,
	output logic exMemRd,
	output logic exMemWr,
	output corePkg::word exResult,
	output corePkg::word exStoreData
);

	corePkg::word opA;
	corePkg::word imm;
	corePkg::aluOp aluSel;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exValid <= 1'b0;
			exRegWr <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
		end else if (!pipeHold) begin
			exValid <= idValid & !idExBubble;
			exRegWr <= idRegWr & !idExBubble;
			exMemRd <= idMemRd & !idExBubble;
			exMemWr <= idMemWr & !idExBubble;
			exPc <= idPc;
			exRd <= idRd;
			opA <= idOpA;
			exStoreData <= idOpB; // Also the second ALU operand
			imm <= idImm;
			aluSel <= idAluOp;
		end
	end

	always_comb begin
		case (aluSel)
			corePkg::aluSub: exResult = opA - exStoreData;
			corePkg::aluAnd: exResult = opA & exStoreData;
			corePkg::aluOr: exResult = opA | exStoreData;
			corePkg::aluSlt: exResult = {31'd0, $signed(opA) < $signed(exStoreData)};
			corePkg::aluAddImm: exResult = opA + imm; // Also load/store address
			default: exResult = opA + exStoreData;
		endcase
	end

endmodule

// ==== hdl/fetchDecode.sv ====
`timescale 1ns/100ps

module fetchDecode #(
	parameter corePkg::word resetPc = 32'h0
) (
	input logic clk,
	input logic rstN,
	input corePkg::instr imemData,
	input logic pcWr,
	input logic ifIdWr,
	input corePkg::fwdSel fwdA,
	input corePkg::fwdSel fwdB,
	input corePkg::word exResult,
	input corePkg::word memFwdData,
	input corePkg::word wbData,
	input logic wbWe,
	input corePkg::regIdx wbRd,
	output corePkg::word imemAddr,
	output corePkg::regIdx idRs,
	output corePkg::regIdx idRt,
	output logic idBranch,
	output logic idValid,
	output corePkg::word idPc,
	output corePkg::word idOpA,
	output corePkg::word idOpB,
	output corePkg::word idImm,
	output corePkg::regIdx idRd,
	output corePkg::aluOp idAluOp,
	output logic idRegWr,
	output logic idMemRd,
	output logic idMemWr
);

	corePkg::word pc;
	corePkg::word ifPc;
	corePkg::instr ifInstr;
	logic ifValid;
	corePkg::word rfA;
	corePkg::word rfB;
	corePkg::word branchTarget;
	logic regWr;
	logic memRd;
	logic memWr;
	logic isBranch;
	logic isBne;
	logic branchTaken;

	function automatic corePkg::word pickOperand(input corePkg::fwdSel sel,
			input corePkg::word regVal);
		case (sel)
			corePkg::fwdEx: return exResult;
			corePkg::fwdMem: return memFwdData;
			corePkg::fwdWb: return wbData;
			default: return regVal;
		endcase
	endfunction

	regFile rf (
		.clk(clk),
		.rA(idRs),
		.rB(idRt),
		.wAddr(wbRd),
		.wEn(wbWe),
		.wData(wbData),
		.rdA(rfA),
		.rdB(rfB)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
			ifValid <= 1'b0;
		end else begin
			if (pcWr)
				pc <= branchTaken ? branchTarget : pc + 32'd4;
			if (ifIdWr) begin
				ifValid <= !branchTaken; // Squash the slot behind a taken branch
				ifInstr <= imemData;
				ifPc <= pc;
			end
		end
	end

	always_comb begin
		idAluOp = corePkg::aluAdd;
		regWr = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		isBranch = 1'b0;
		isBne = 1'b0;
		case (ifInstr[31:26])
			corePkg::opSpecial: begin
				regWr = 1'b1;
				case (ifInstr[5:0])
					corePkg::fnAddu: idAluOp = corePkg::aluAdd;
					corePkg::fnSubu: idAluOp = corePkg::aluSub;
					corePkg::fnAnd: idAluOp = corePkg::aluAnd;
					corePkg::fnOr: idAluOp = corePkg::aluOr;
					corePkg::fnSlt: idAluOp = corePkg::aluSlt;
					default: regWr = 1'b0;
				endcase
			end
			corePkg::opAddiu: begin
				idAluOp = corePkg::aluAddImm;
				regWr = 1'b1;
			end
			corePkg::opLw: begin
				idAluOp = corePkg::aluAddImm;
				regWr = 1'b1;
				memRd = 1'b1;
			end
			corePkg::opSw: begin
				idAluOp = corePkg::aluAddImm;
				memWr = 1'b1;
			end
			corePkg::opBeq: isBranch = 1'b1;
			corePkg::opBne: begin
				isBranch = 1'b1;
				isBne = 1'b1;
			end
			default: ;
		endcase
	end

	assign imemAddr = pc;
	assign idValid = ifValid;
	assign idPc = ifPc;
	assign idRs = ifInstr[25:21];
	assign idRt = ifInstr[20:16];
	assign idRd = (ifInstr[31:26] == corePkg::opSpecial) ? ifInstr[15:11] : ifInstr[20:16];
	assign idImm = {{16{ifInstr[15]}}, ifInstr[15:0]};
	assign idRegWr = ifValid & regWr;
	assign idMemRd = ifValid & memRd;
	assign idMemWr = ifValid & memWr;
	assign idBranch = ifValid & isBranch;

	always_comb begin
		idOpA = pickOperand(fwdA, rfA);
		idOpB = pickOperand(fwdB, rfB);
	end

	// Branch resolves in ID on forwarded operands
	assign branchTarget = ifPc + 32'd4 + {idImm[29:0], 2'b00};
	assign branchTaken = idBranch & ((idOpA == idOpB) ^ isBne);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
	input corePkg::regIdx idRs,
	input corePkg::regIdx idRt,
	input logic idBranch,
	input corePkg::regIdx exRd,
	input logic exRegWr,
	input logic exMemRd,
	input corePkg::regIdx memRd,
	input logic memRegWr,
	input logic memMemRd,
	input corePkg::regIdx wbRd,
	input logic wbRegWr,
	input logic memBusy,
	output corePkg::fwdSel fwdA,
	output corePkg::fwdSel fwdB,
	output logic pcWr,
	output logic ifIdWr,
	output logic idExBubble,
	output logic pipeHold
);

	logic exLoadHit;
	logic memLoadHit;
	logic loadStall;

	// Nearest producer wins
	function automatic corePkg::fwdSel pickFwd(input corePkg::regIdx src);
		if (src == 5'd0)
			return corePkg::fwdNone;
		else if (exRegWr && exRd == src)
			return corePkg::fwdEx;
		else if (memRegWr && memRd == src)
			return corePkg::fwdMem;
		else if (wbRegWr && wbRd == src)
			return corePkg::fwdWb;
		else
			return corePkg::fwdNone;
	endfunction

	always_comb begin
		fwdA = pickFwd(idRs);
		fwdB = pickFwd(idRt);
	end

	// Load data is not there yet for the ID operand
	assign exLoadHit = exMemRd && exRd != 5'd0 && (exRd == idRs || exRd == idRt);

	// Branch compare cannot wait on the bus read path
	assign memLoadHit = idBranch && memMemRd && memRd != 5'd0
		&& (memRd == idRs || memRd == idRt);

	assign loadStall = exLoadHit | memLoadHit;

	assign pipeHold = memBusy;

	always_comb begin
		if (memBusy) begin
			pcWr = 1'b0;
			ifIdWr = 1'b0;
			idExBubble = 1'b0; // Freeze wins over bubble
		end else if (loadStall) begin
			pcWr = 1'b0;
			ifIdWr = 1'b0;
			idExBubble = 1'b1;
		end else begin
			pcWr = 1'b1;
			ifIdWr = 1'b1;
			idExBubble = 1'b0;
		end
	end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input corePkg::regIdx rA,
	input corePkg::regIdx rB,
	input corePkg::regIdx wAddr,
	input logic wEn,
	input corePkg::word wData,
	output corePkg::word rdA,
	output corePkg::word rdB
);

	corePkg::word regs [32];

	// Same-cycle write shows up on the read side
	function automatic corePkg::word readPort(input corePkg::regIdx idx);
		if (idx == 5'd0)
			return '0;
		else if (wEn && wAddr == idx)
			return wData;
		else
			return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (wEn && wAddr != 5'd0)
			regs[wAddr] <= wData;
	end

	always_comb begin
		rdA = readPort(rA);
		rdB = readPort(rB);
	end

endmodule

// ==== hdl/corePkg.sv ====
package corePkg;

	typedef logic [31:0] word;
	typedef logic [4:0] regIdx;
	typedef logic [31:0] instr;
	typedef logic [1:0] fwdSel;
	typedef logic [2:0] aluOp;

	localparam fwdSel fwdNone = 2'd0;
	localparam fwdSel fwdEx = 2'd1;
	localparam fwdSel fwdMem = 2'd2;
	localparam fwdSel fwdWb = 2'd3;

	localparam aluOp aluAdd = 3'd0;
	localparam aluOp aluSub = 3'd1;
	localparam aluOp aluAnd = 3'd2;
	localparam aluOp aluOr = 3'd3;
	localparam aluOp aluSlt = 3'd4;
	localparam aluOp aluAddImm = 3'd5; // Base plus sign-extended immediate

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

endpackage
